// ==== sources.f ====
hdl/issue_pkg.sv
hdl/instruction_decoder.sv
hdl/issue_stage.sv
hdl/register_file.sv
hdl/operand_scoreboard.sv
hdl/unit_operand_prep.sv
hdl/decode_issue_top.sv
testbench/issue_checker.sv
testbench/tb_decode_issue.sv

// ==== Makefile ====
SHELL := /bin/bash

.PHONY: all run clean

all: run

obj_dir/Vtb_decode_issue: sources.f $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert --top-module tb_decode_issue \
		-f sources.f -o Vtb_decode_issue

run: obj_dir/Vtb_decode_issue
	set -o pipefail; ./obj_dir/Vtb_decode_issue | tee sim.log
	! grep -q "Something failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_decode_issue.sv ====
`default_nettype none

module tb_decode_issue;
    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    localparam int NUM_INSTR      = 400;
    localparam int ACCEPT_TIMEOUT = 40000;
    localparam int DRAIN_TIMEOUT  = 2000;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       decode_valid = 1'b0;
    word_t      decode_pc = '0;
    word_t      decode_instruction = '0;
    logic       decode_advance;
    logic       wb_valid = 1'b0;
    reg_addr_t  wb_rd = '0;
    word_t      wb_data = '0;
    logic       alu_ready = 1'b0;
    logic       branch_ready = 1'b0;
    logic       ls_ready = 1'b0;
    logic       alu_issue;
    logic       branch_issue;
    logic       ls_issue;
    logic       illegal_instruction;
    word_t      alu_in1;
    word_t      alu_in2;
    fn3_t       alu_fn3;
    logic       alu_subtract;
    logic       alu_arith_shift;
    word_t      ls_base;
    word_t      ls_store_data;
    word_t      ls_offset;
    logic       ls_load;
    logic       ls_store;
    fn3_t       ls_fn3;
    word_t      br_pc;
    word_t      br_offset;
    word_t      br_rs1;
    word_t      br_rs2;
    fn3_t       br_fn3;
    logic       br_jal;
    logic       br_jalr;
    logic       br_signed;

    integer      seed = 15018;
    int          offered = 0;
    word_t       next_pc = 32'h0000_1000;
    logic [31:0] rnd;
    int          pick;
    reg_addr_t   candidates [$];
    int          wait_cycles;
    bit          timed_out = 1'b0;

    decode_issue_top i_dut (.*);

    issue_checker i_checker (.*);

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Stimulus

    // Nine opcodes plus M-extension and system/fence patterns that no unit claims
    function automatic word_t random_instruction();
        logic [31:0] bits;
        logic [31:0] fields;
        int kind;
        logic [4:0] op;
        word_t instr;
        bits = $random(seed);
        fields = $random(seed);
        kind = int'(fields[30:24]) % 11;
        case (kind)
            0:       op = LUI;
            1:       op = AUIPC;
            2:       op = JAL;
            3:       op = JALR;
            4:       op = BRANCH;
            5:       op = LOAD;
            6:       op = STORE;
            7:       op = ARITH_IMM;
            8, 9:    op = ARITH;
            default: op = bits[0] ? 5'b11100 : 5'b00011;
        endcase
        instr = bits;
        instr[6:0] = {op, 2'b11};
        // Few registers, so hazards come often
        instr[11:7] = {2'b00, fields[2:0]};
        instr[19:15] = {2'b00, fields[5:3]};
        instr[24:20] = {2'b00, fields[8:6]};
        if (op == ARITH) begin
            instr[25] = (kind == 9);
        end
        return instr;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            decode_valid <= 1'b0;
            wb_valid <= 1'b0;
            alu_ready <= 1'b0;
            branch_ready <= 1'b0;
            ls_ready <= 1'b0;
        end else begin
            // Front end keeps its instruction until the stage takes it
            if (!decode_valid || decode_advance) begin
                rnd = $random(seed);
                if (offered < NUM_INSTR && rnd[2:0] != 3'b000) begin
                    decode_valid <= 1'b1;
                    decode_instruction <= random_instruction();
                    decode_pc <= next_pc;
                    next_pc = next_pc + 32'd4;
                    offered = offered + 1;
                end else begin
                    decode_valid <= 1'b0;
                end
            end

            rnd = $random(seed);
            alu_ready <= rnd[1:0] != 2'b00;
            branch_ready <= rnd[3:2] != 2'b00;
            ls_ready <= rnd[5:4] != 2'b00;

            // Writeback returns a result only for a register still in flight
            candidates.delete();
            for (int r = 1; r < NUM_REGS; r++) begin
                if (i_checker.model_pending[r] && !(wb_valid && wb_rd == reg_addr_t'(r))) begin
                    candidates.push_back(reg_addr_t'(r));
                end
            end
            if (rnd[8] && candidates.size() > 0) begin
                pick = int'(rnd[30:16]) % candidates.size();
                wb_valid <= 1'b1;
                wb_rd <= candidates[pick];
                wb_data <= $random(seed);
            end else begin
                wb_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Run control

    initial begin
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (wait_cycles = 0; wait_cycles < ACCEPT_TIMEOUT
                && i_checker.accept_count < NUM_INSTR; wait_cycles++) begin
            @(posedge clk);
        end
        if (i_checker.accept_count < NUM_INSTR) begin
            $display("Timeout: only %0d of %0d instructions were accepted",
                     i_checker.accept_count, NUM_INSTR);
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            // Last instruction may still wait on a writeback
            for (wait_cycles = 0; wait_cycles < DRAIN_TIMEOUT
                    && i_checker.event_count < i_checker.accept_count; wait_cycles++) begin
                @(posedge clk);
            end
            if (i_checker.event_count < i_checker.accept_count) begin
                $display("Timeout: the last accepted instruction never issued");
                timed_out = 1'b1;
            end
        end

        // Checker finishes the compares of the current edge
        @(negedge clk);

        $display("Accepted %0d, issue events %0d, checks %0d, errors %0d",
                 i_checker.accept_count, i_checker.event_count,
                 i_checker.check_count, i_checker.error_count);
        if (timed_out || i_checker.error_count != 0) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/issue_checker.sv ====
`default_nettype none

module issue_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 decode_valid,
    input issue_pkg::word_t     decode_pc,
    input issue_pkg::word_t     decode_instruction,
    input logic                 decode_advance,
    input logic                 wb_valid,
    input issue_pkg::reg_addr_t wb_rd,
    input issue_pkg::word_t     wb_data,
    input logic                 alu_ready,
    input logic                 branch_ready,
    input logic                 ls_ready,
    input logic                 alu_issue,
    input logic                 branch_issue,
    input logic                 ls_issue,
    input logic                 illegal_instruction,
    input issue_pkg::word_t     alu_in1,
    input issue_pkg::word_t     alu_in2,
    input issue_pkg::fn3_t      alu_fn3,
    input logic                 alu_subtract,
    input logic                 alu_arith_shift,
    input issue_pkg::word_t     ls_base,
    input issue_pkg::word_t     ls_store_data,
    input issue_pkg::word_t     ls_offset,
    input logic                 ls_load,
    input logic                 ls_store,
    input issue_pkg::fn3_t      ls_fn3,
    input issue_pkg::word_t     br_pc,
    input issue_pkg::word_t     br_offset,
    input issue_pkg::word_t     br_rs1,
    input issue_pkg::word_t     br_rs2,
    input issue_pkg::fn3_t      br_fn3,
    input logic                 br_jal,
    input logic                 br_jalr,
    input logic                 br_signed
);
    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    // Reference model state
    word_t               model_regs [NUM_REGS];
    logic [NUM_REGS-1:0] model_pending;
    issue_state_t        held_state = EMPTY;
    word_t               held_pc;
    word_t               held_instr;

    int accept_count = 0;
    int event_count = 0;
    int check_count = 0;
    int error_count = 0;

    // Per-cycle expectations
    logic [4:0] op;
    fn3_t       fn3;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
    logic [2:0] usage;
    unit_mask_t exp_mask;
    unit_mask_t ready_vec;
    unit_mask_t exp_pulses;
    logic       src_blocked;
    logic       exp_issue;
    logic       exp_illegal;
    logic       exp_advance;
    logic       any_issue;

    ////////////////////////////////////////
    // Decode rules, RV32I base formats

    function automatic unit_mask_t units_needed(word_t instr);
        unit_mask_t mask;
        mask = '0;
        case (instr[6:2])
            ARITH:                 mask[UNIT_ALU] = !instr[25];
            ARITH_IMM, LUI, AUIPC: mask[UNIT_ALU] = 1'b1;
            JAL, JALR: begin
                mask[UNIT_ALU] = 1'b1;
                mask[UNIT_BRANCH] = 1'b1;
            end
            BRANCH:                mask[UNIT_BRANCH] = 1'b1;
            LOAD, STORE:           mask[UNIT_LS] = 1'b1;
            default:               mask = '0;
        endcase
        return mask;
    endfunction

    // Bits are rs1, rs2, rd
    function automatic logic [2:0] register_usage(word_t instr);
        case (instr[6:2])
            LUI, AUIPC, JAL:        return 3'b001;
            JALR, LOAD, ARITH_IMM:  return 3'b101;
            BRANCH, STORE:          return 3'b110;
            ARITH:                  return 3'b111;
            default:                return 3'b000;
        endcase
    endfunction

    function automatic word_t immediate_value(word_t i);
        case (i[6:2])
            STORE:      return {{20{i[31]}}, i[31:25], i[11:7]};
            BRANCH:     return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            LUI, AUIPC: return {i[31:12], 12'b0};
            JAL:        return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            default:    return {{20{i[31]}}, i[31:20]};
        endcase
    endfunction

    task automatic compare_value(input string name, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Cycle compare and model update

    always @(posedge clk) begin
        if (rst) begin
            held_state <= EMPTY;
            model_pending <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                model_regs[r] <= '0;
            end
        end else begin
            op = held_instr[6:2];
            fn3 = held_instr[14:12];
            rs1_val = model_regs[held_instr[19:15]];
            rs2_val = model_regs[held_instr[24:20]];
            imm = immediate_value(held_instr);
            usage = register_usage(held_instr);
            exp_mask = (held_state == HELD) ? units_needed(held_instr) : '0;

            ready_vec = '0;
            ready_vec[UNIT_ALU] = alu_ready;
            ready_vec[UNIT_BRANCH] = branch_ready;
            ready_vec[UNIT_LS] = ls_ready;

            src_blocked = (usage[2] && model_pending[held_instr[19:15]])
                || (usage[1] && model_pending[held_instr[24:20]]);
            exp_illegal = (held_state == HELD) && (exp_mask == '0);
            exp_issue = (held_state == HELD) && (exp_mask != '0) && !src_blocked
                && ((exp_mask & ready_vec) == exp_mask);
            exp_pulses = exp_issue ? exp_mask : '0;
            exp_advance = decode_valid && ((held_state == EMPTY) || exp_issue || exp_illegal);

            compare_value("alu_issue", 32'(alu_issue), 32'(exp_pulses[UNIT_ALU]));
            compare_value("branch_issue", 32'(branch_issue), 32'(exp_pulses[UNIT_BRANCH]));
            compare_value("ls_issue", 32'(ls_issue), 32'(exp_pulses[UNIT_LS]));
            compare_value("illegal_instruction", 32'(illegal_instruction), 32'(exp_illegal));
            compare_value("decode_advance", 32'(decode_advance), 32'(exp_advance));

            if (alu_issue && exp_pulses[UNIT_ALU]) begin
                case (op)
                    AUIPC, JAL, JALR: compare_value("alu_in1", alu_in1, held_pc);
                    LUI:              compare_value("alu_in1", alu_in1, '0);
                    default:          compare_value("alu_in1", alu_in1, rs1_val);
                endcase
                case (op)
                    ARITH:     compare_value("alu_in2", alu_in2, rs2_val);
                    JAL, JALR: compare_value("alu_in2", alu_in2, 32'd4);
                    default:   compare_value("alu_in2", alu_in2, imm);
                endcase
                compare_value("alu_fn3", 32'(alu_fn3),
                              32'((op == ARITH || op == ARITH_IMM) ? fn3 : 3'b000));
                compare_value("alu_subtract", 32'(alu_subtract),
                              32'((op == ARITH && fn3 == 3'b000 && held_instr[30])
                              || ((op == ARITH || op == ARITH_IMM)
                              && (fn3 == 3'b010 || fn3 == 3'b011))));
                compare_value("alu_arith_shift", 32'(alu_arith_shift), 32'(held_instr[30]));
            end

            if (ls_issue && exp_pulses[UNIT_LS]) begin
                compare_value("ls_base", ls_base, rs1_val);
                compare_value("ls_store_data", ls_store_data, rs2_val);
                compare_value("ls_offset", ls_offset, imm);
                compare_value("ls_load", 32'(ls_load), 32'(op == LOAD));
                compare_value("ls_store", 32'(ls_store), 32'(op == STORE));
                compare_value("ls_fn3", 32'(ls_fn3), 32'(fn3));
            end

            if (branch_issue && exp_pulses[UNIT_BRANCH]) begin
                compare_value("br_pc", br_pc, held_pc);
                compare_value("br_offset", br_offset, imm);
                compare_value("br_rs1", br_rs1, rs1_val);
                compare_value("br_rs2", br_rs2, rs2_val);
                compare_value("br_fn3", 32'(br_fn3), 32'(fn3));
                compare_value("br_jal", 32'(br_jal), 32'(op == JAL));
                compare_value("br_jalr", 32'(br_jalr), 32'(op == JALR));
                // Only BLTU and BGEU compare unsigned
                compare_value("br_signed", 32'(br_signed),
                              32'(!(fn3 == 3'b110 || fn3 == 3'b111)));
            end

            // Model update from the expected events
            any_issue = alu_issue || branch_issue || ls_issue;
            if (wb_valid) begin
                if (wb_rd != '0) begin
                    model_regs[wb_rd] <= wb_data;
                end
                model_pending[wb_rd] <= 1'b0;
            end
            // A new claim overrides a writeback to the same register
            if (exp_issue && usage[0] && held_instr[11:7] != '0) begin
                model_pending[held_instr[11:7]] <= 1'b1;
            end
            if (any_issue || illegal_instruction) begin
                event_count <= event_count + 1;
            end
            if (decode_advance) begin
                held_state <= HELD;
                held_pc <= decode_pc;
                held_instr <= decode_instruction;
                accept_count <= accept_count + 1;
            end else if (exp_issue || exp_illegal) begin
                held_state <= EMPTY;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decode_issue_top.sv ====
`default_nettype none

module decode_issue_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 decode_valid,
    input  issue_pkg::word_t     decode_pc,
    input  issue_pkg::word_t     decode_instruction,
    output logic                 decode_advance,
    input  logic                 wb_valid,
    input  issue_pkg::reg_addr_t wb_rd,
    input  issue_pkg::word_t     wb_data,
    input  logic                 alu_ready,
    input  logic                 branch_ready,
    input  logic                 ls_ready,
    output logic                 alu_issue,
    output logic                 branch_issue,
    output logic                 ls_issue,
    output logic                 illegal_instruction,
    output issue_pkg::word_t     alu_in1,
    output issue_pkg::word_t     alu_in2,
    output issue_pkg::fn3_t      alu_fn3,
    output logic                 alu_subtract,
    output logic                 alu_arith_shift,
    output issue_pkg::word_t     ls_base,
    output issue_pkg::word_t     ls_store_data,
    output issue_pkg::word_t     ls_offset,
    output logic                 ls_load,
    output logic                 ls_store,
    output issue_pkg::fn3_t      ls_fn3,
    output issue_pkg::word_t     br_pc,
    output issue_pkg::word_t     br_offset,
    output issue_pkg::word_t     br_rs1,
    output issue_pkg::word_t     br_rs2,
    output issue_pkg::fn3_t      br_fn3,
    output logic                 br_jal,
    output logic                 br_jalr,
    output logic                 br_signed
);
    import issue_pkg::*;

    // Decode side
    unit_mask_t dec_mask;
    logic dec_uses_rs1;
    logic dec_uses_rs2;
    logic dec_uses_rd;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    fn3_t dec_fn3;
    word_t dec_imm;

    // Issue side
    word_t held_pc;
    word_t held_instruction;
    word_t held_imm;
    reg_addr_t held_rs1;
    reg_addr_t held_rs2;
    reg_addr_t held_rd;
    fn3_t held_fn3;
    logic held_uses_rs1;
    logic held_uses_rs2;
    unit_mask_t held_mask;
    logic rd_claim;
    logic rs1_pending;
    logic rs2_pending;
    word_t rs1_data;
    word_t rs2_data;

    instruction_decoder i_decoder (
        .instruction (decode_instruction),
        .unit_mask   (dec_mask),
        .uses_rs1    (dec_uses_rs1),
        .uses_rs2    (dec_uses_rs2),
        .uses_rd     (dec_uses_rd),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rd          (dec_rd),
        .fn3         (dec_fn3),
        .imm         (dec_imm)
    );

    issue_stage i_issue (
        .clk, .rst, .decode_valid, .decode_pc, .decode_instruction,
        .unit_mask (dec_mask),
        .uses_rs1  (dec_uses_rs1),
        .uses_rs2  (dec_uses_rs2),
        .uses_rd   (dec_uses_rd),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .fn3       (dec_fn3),
        .imm       (dec_imm),
        .rs1_pending, .rs2_pending, .alu_ready, .branch_ready, .ls_ready,
        .decode_advance, .held_pc, .held_instruction, .held_imm,
        .held_rs1, .held_rs2, .held_rd, .held_fn3,
        .held_uses_rs1, .held_uses_rs2, .held_mask, .rd_claim,
        .alu_issue, .branch_issue, .ls_issue, .illegal_instruction
    );

    register_file i_regfile (
        .clk, .rst, .wb_valid, .wb_rd, .wb_data,
        .rs1      (held_rs1),
        .rs2      (held_rs2),
        .rs1_data, .rs2_data
    );

    operand_scoreboard i_scoreboard (
        .clk, .rst, .rd_claim,
        .claim_rd (held_rd),
        .wb_valid, .wb_rd,
        .rs1      (held_rs1),
        .rs2      (held_rs2),
        .uses_rs1 (held_uses_rs1),
        .uses_rs2 (held_uses_rs2),
        .rs1_pending, .rs2_pending
    );

    unit_operand_prep i_prep (
        .held_pc, .held_instruction, .held_imm, .held_fn3, .rs1_data, .rs2_data,
        .alu_in1, .alu_in2, .alu_fn3, .alu_subtract, .alu_arith_shift,
        .ls_base, .ls_store_data, .ls_offset, .ls_load, .ls_store, .ls_fn3,
        .br_pc, .br_offset, .br_rs1, .br_rs2, .br_fn3, .br_jal, .br_jalr, .br_signed
    );

endmodule

`default_nettype wire

// ==== hdl/unit_operand_prep.sv ====
`default_nettype none

module unit_operand_prep (
    input  issue_pkg::word_t held_pc,
    input  issue_pkg::word_t held_instruction,
    input  issue_pkg::word_t held_imm,
    input  issue_pkg::fn3_t  held_fn3,
    input  issue_pkg::word_t rs1_data,
    input  issue_pkg::word_t rs2_data,
    output issue_pkg::word_t alu_in1,
    output issue_pkg::word_t alu_in2,
    output issue_pkg::fn3_t  alu_fn3,
    output logic             alu_subtract,
    output logic             alu_arith_shift,
    output issue_pkg::word_t ls_base,
    output issue_pkg::word_t ls_store_data,
    output issue_pkg::word_t ls_offset,
    output logic             ls_load,
    output logic             ls_store,
    output issue_pkg::fn3_t  ls_fn3,
    output issue_pkg::word_t br_pc,
    output issue_pkg::word_t br_offset,
    output issue_pkg::word_t br_rs1,
    output issue_pkg::word_t br_rs2,
    output issue_pkg::fn3_t  br_fn3,
    output logic             br_jal,
    output logic             br_jalr,
    output logic             br_signed
);
    import issue_pkg::*;

    opcode_t opcode;
    logic arith_op;

    assign opcode = opcode_t'(held_instruction[6:2]);
    assign arith_op = opcode inside {ARITH, ARITH_IMM};

    ////////////////////////////////////////
    // ALU operands

    always_comb begin
        case (opcode)
            AUIPC, JAL, JALR: alu_in1 = held_pc;
            LUI:              alu_in1 = '0;
            default:          alu_in1 = rs1_data;
        endcase
    end

    // Jumps compute the link address pc + 4
    always_comb begin
        case (opcode)
            ARITH:     alu_in2 = rs2_data;
            JAL, JALR: alu_in2 = 32'd4;
            default:   alu_in2 = held_imm;
        endcase
    end

    assign alu_fn3 = arith_op ? held_fn3 : ADD_SUB_FN3;

    // SUB, and the compare for SLT[U][I]
    assign alu_subtract =
        ((opcode == ARITH) && (held_fn3 == ADD_SUB_FN3) && held_instruction[30])
        || (arith_op && (held_fn3 inside {SLT_FN3, SLTU_FN3}));
    assign alu_arith_shift = held_instruction[30];

    ////////////////////////////////////////
    // Load-store operands

    assign ls_base       = rs1_data;
    assign ls_store_data = rs2_data;
    assign ls_offset     = held_imm;
    assign ls_load       = (opcode == LOAD);
    assign ls_store      = (opcode == STORE);
    assign ls_fn3        = held_fn3;

    ////////////////////////////////////////
    // Branch operands

    assign br_pc     = held_pc;
    assign br_offset = held_imm;
    assign br_rs1    = rs1_data;
    assign br_rs2    = rs2_data;
    assign br_fn3    = held_fn3;
    assign br_jal    = (opcode == JAL);
    assign br_jalr   = (opcode == JALR);
    assign br_signed = !(held_fn3 inside {BLTU_FN3, BGEU_FN3});

endmodule

`default_nettype wire

// ==== hdl/operand_scoreboard.sv ====
`default_nettype none

module operand_scoreboard (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd_claim,
    input  issue_pkg::reg_addr_t claim_rd,
    input  logic                 wb_valid,
    input  issue_pkg::reg_addr_t wb_rd,
    input  issue_pkg::reg_addr_t rs1,
    input  issue_pkg::reg_addr_t rs2,
    input  logic                 uses_rs1,
    input  logic                 uses_rs2,
    output logic                 rs1_pending,
    output logic                 rs2_pending
);
    import issue_pkg::*;

    logic [NUM_REGS-1:0] pending;

    // Claim is applied last so that it wins over a writeback to the same rd
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_rd] <= 1'b0;
            end
            if (rd_claim && (claim_rd != '0)) begin
                pending[claim_rd] <= 1'b1;
            end
        end
    end

    assign rs1_pending = uses_rs1 && pending[rs1];
    assign rs2_pending = uses_rs2 && pending[rs2];

    ////////////////////////////////////////
    // Assertions

    // Writeback only returns results that were issued earlier
    wb_matches_claim: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> pending[wb_rd]);

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`default_nettype none

module register_file (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_valid,
    input  issue_pkg::reg_addr_t wb_rd,
    input  issue_pkg::word_t     wb_data,
    input  issue_pkg::reg_addr_t rs1,
    input  issue_pkg::reg_addr_t rs2,
    output issue_pkg::word_t     rs1_data,
    output issue_pkg::word_t     rs2_data
);
    import issue_pkg::*;

    // x1 to x31, x0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    ////////////////////////////////////////
    // Read ports, no bypass

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/issue_stage.sv ====
`default_nettype none

module issue_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  decode_valid,
    input  issue_pkg::word_t      decode_pc,
    input  issue_pkg::word_t      decode_instruction,
    input  issue_pkg::unit_mask_t unit_mask,
    input  logic                  uses_rs1,
    input  logic                  uses_rs2,
    input  logic                  uses_rd,
    input  issue_pkg::reg_addr_t  rs1,
    input  issue_pkg::reg_addr_t  rs2,
    input  issue_pkg::reg_addr_t  rd,
    input  issue_pkg::fn3_t       fn3,
    input  issue_pkg::word_t      imm,
    input  logic                  rs1_pending,
    input  logic                  rs2_pending,
    input  logic                  alu_ready,
    input  logic                  branch_ready,
    input  logic                  ls_ready,
    output logic                  decode_advance,
    output issue_pkg::word_t      held_pc,
    output issue_pkg::word_t      held_instruction,
    output issue_pkg::word_t      held_imm,
    output issue_pkg::reg_addr_t  held_rs1,
    output issue_pkg::reg_addr_t  held_rs2,
    output issue_pkg::reg_addr_t  held_rd,
    output issue_pkg::fn3_t       held_fn3,
    output logic                  held_uses_rs1,
    output logic                  held_uses_rs2,
    output issue_pkg::unit_mask_t held_mask,
    output logic                  rd_claim,
    output logic                  alu_issue,
    output logic                  branch_issue,
    output logic                  ls_issue,
    output logic                  illegal_instruction
);
    import issue_pkg::*;

    issue_state_t state;
    logic held_uses_rd;
    unit_mask_t unit_ready;
    logic operands_ready;
    logic issue_now;
    logic stage_ready;

    ////////////////////////////////////////
    // Issue decision

    assign unit_ready[UNIT_ALU]    = alu_ready;
    assign unit_ready[UNIT_BRANCH] = branch_ready;
    assign unit_ready[UNIT_LS]     = ls_ready;

    assign operands_ready = !rs1_pending && !rs2_pending;

    // Every needed unit ready, and at least one needed
    assign issue_now = (state == HELD) && (held_mask != '0) && operands_ready
        && ((held_mask & unit_ready) == held_mask);

    // Unclaimed pattern is dropped without waiting on operands
    assign illegal_instruction = (state == HELD) && (held_mask == '0);

    assign stage_ready = (state == EMPTY) || issue_now || illegal_instruction;
    assign decode_advance = decode_valid && stage_ready;

    assign alu_issue    = issue_now && held_mask[UNIT_ALU];
    assign branch_issue = issue_now && held_mask[UNIT_BRANCH];
    assign ls_issue     = issue_now && held_mask[UNIT_LS];

    assign rd_claim = issue_now && held_uses_rd && (held_rd != '0);

    ////////////////////////////////////////
    // Issue register

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
        end else if (decode_advance) begin
            state <= HELD;
        end else if (stage_ready) begin
            state <= EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            held_pc          <= decode_pc;
            held_instruction <= decode_instruction;
            held_imm         <= imm;
            held_rs1         <= rs1;
            held_rs2         <= rs2;
            held_rd          <= rd;
            held_fn3         <= fn3;
            held_uses_rs1    <= uses_rs1;
            held_uses_rs2    <= uses_rs2;
            held_uses_rd     <= uses_rd;
            held_mask        <= unit_mask;
        end
    end

    ////////////////////////////////////////
    // Assertions

    // Issue only from an instruction accepted earlier and not yet consumed
    no_issue_when_empty: assert property (@(posedge clk) disable iff (rst)
        (alu_issue || branch_issue || ls_issue)
        |-> $past(decode_advance) || $past((state == HELD) && !stage_ready));

    // A dropped instruction never issues afterwards
    illegal_excludes_issue: assert property (@(posedge clk) disable iff (rst)
        (illegal_instruction && !decode_advance)
        |=> !(alu_issue || branch_issue || ls_issue || illegal_instruction));

endmodule

`default_nettype wire

// ==== hdl/instruction_decoder.sv ====
`default_nettype none

module instruction_decoder (
    input  issue_pkg::word_t      instruction,
    output issue_pkg::unit_mask_t unit_mask,
    output logic                  uses_rs1,
    output logic                  uses_rs2,
    output logic                  uses_rd,
    output issue_pkg::reg_addr_t  rs1,
    output issue_pkg::reg_addr_t  rs2,
    output issue_pkg::reg_addr_t  rd,
    output issue_pkg::fn3_t       fn3,
    output issue_pkg::word_t      imm
);
    import issue_pkg::*;

    opcode_t opcode;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign opcode = opcode_t'(instruction[6:2]);

    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];
    assign rd  = instruction[11:7];
    assign fn3 = instruction[14:12];

    ////////////////////////////////////////
    // Register usage

    assign uses_rs1 = !(opcode inside {LUI, AUIPC, JAL});
    assign uses_rs2 = opcode inside {BRANCH, STORE, ARITH};
    assign uses_rd  = !(opcode inside {BRANCH, STORE});

    ////////////////////////////////////////
    // Unit selection

    // Bit 25 set in ARITH is multiply/divide, not handled here
    always_comb begin
        unit_mask = '0;
        unit_mask[UNIT_ALU] = ((opcode == ARITH) && !instruction[25])
            || (opcode inside {ARITH_IMM, LUI, AUIPC, JAL, JALR});
        unit_mask[UNIT_BRANCH] = opcode inside {BRANCH, JAL, JALR};
        unit_mask[UNIT_LS] = opcode inside {LOAD, STORE};
    end

    ////////////////////////////////////////
    // Immediates

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        case (opcode)
            STORE:       imm = imm_s;
            BRANCH:      imm = imm_b;
            LUI, AUIPC:  imm = imm_u;
            JAL:         imm = imm_j;
            // LOAD, JALR, ARITH_IMM and anything unclaimed
            default:     imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    ////////////////////////////////////////
    // Widths

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [2:0] fn3_t;

    localparam int NUM_REGS = 32;

    ////////////////////////////////////////
    // Opcodes, instruction bits [6:2]

    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011
    } opcode_t;

    ////////////////////////////////////////
    // Execution units

    typedef logic [2:0] unit_mask_t;

    localparam int UNIT_ALU    = 0;
    localparam int UNIT_BRANCH = 1;
    localparam int UNIT_LS     = 2;

    ////////////////////////////////////////
    // Function field codes

    localparam fn3_t ADD_SUB_FN3 = 3'b000;
    localparam fn3_t SLT_FN3     = 3'b010;
    localparam fn3_t SLTU_FN3    = 3'b011;
    // Unsigned branch compares
    localparam fn3_t BLTU_FN3    = 3'b110;
    localparam fn3_t BGEU_FN3    = 3'b111;

    ////////////////////////////////////////
    // Issue register state

    typedef enum logic {
        EMPTY,
        HELD
    } issue_state_t;

endpackage

`default_nettype wire
